// File: design/rvseed_defs.svh
// rvseed widths and encodings
`ifndef RVSEED_DEFS_SVH
`define RVSEED_DEFS_SVH

`define RVSEED_XLEN       64
`define RVSEED_REG_NUM    32
`define RVSEED_REG_AW     5
`define RVSEED_AXI_AW     32

// major opcodes
`define RVSEED_OPC_OP     7'b0110011
`define RVSEED_OPC_OPIMM  7'b0010011
`define RVSEED_OPC_LOAD   7'b0000011

`define RVSEED_RESP_OKAY  2'b00

`endif

// File: design/rvseed_pkg.sv
// rvseed shared types
`default_nettype none

`include "rvseed_defs.svh"

package rvseed_pkg;

    typedef struct packed {
        logic [6:0]                 funct7;
        logic [`RVSEED_REG_AW-1:0]  rs2;
        logic [`RVSEED_REG_AW-1:0]  rs1;
        logic [2:0]                 funct3;
        logic [`RVSEED_REG_AW-1:0]  rd;
        logic [6:0]                 opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]                imm12;
        logic [`RVSEED_REG_AW-1:0]  rs1;
        logic [2:0]                 funct3;
        logic [`RVSEED_REG_AW-1:0]  rd;
        logic [6:0]                 opcode;
    } i_fmt_t;

    // same word, register or immediate layout
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } inst_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {LD_B, LD_H, LD_W, LD_D} load_sz_e; // matches funct3[1:0]

    typedef struct packed {
        logic                       valid;
        logic                       is_load;
        logic                       illegal;
        logic [`RVSEED_REG_AW-1:0]  rd;
        alu_op_e                    alu_op;
        load_sz_e                   ld_sz;
        logic                       ld_uns;  // zero extend
        logic [`RVSEED_XLEN-1:0]    op_a;
        logic [`RVSEED_XLEN-1:0]    op_b;    // rs2 or sign-extended imm
    } issue_t;

    typedef struct packed {
        logic                       valid;
        logic [`RVSEED_REG_AW-1:0]  rd;
        logic [`RVSEED_XLEN-1:0]    data;
        logic                       illegal;
        logic                       fault;
    } wb_t;

    typedef struct packed {
        logic                       valid;
        logic [`RVSEED_REG_AW-1:0]  rd;
        logic [`RVSEED_XLEN-1:0]    data;
        logic                       illegal;
        logic                       fault;
    } retire_t;

    typedef struct packed {
        logic                       wen;
        logic [`RVSEED_REG_AW-1:0]  waddr;
    } rd_port_t;

endpackage

`default_nettype wire

// File: design/id_stage.sv
// instruction decode and issue
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_defs.svh"

module id_stage import rvseed_pkg::*; (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire                         inst_valid_i,
    input  wire inst_u                  inst_i,
    input  wire [`RVSEED_XLEN-1:0]      rs1_data_i,
    input  wire [`RVSEED_XLEN-1:0]      rs2_data_i,
    input  wire rd_port_t               wb_port_i,
    input  wire                         mem_busy_i,
    output logic                        inst_ready_o,
    output logic [`RVSEED_REG_AW-1:0]   rs1_addr_o,
    output logic [`RVSEED_REG_AW-1:0]   rs2_addr_o,
    output issue_t                      issue_o
);

    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic [5:0]                 funct6;
    logic [`RVSEED_REG_AW-1:0]  rd;
    logic [`RVSEED_XLEN-1:0]    imm_sext;
    logic                       dec_illegal, dec_load, use_rs2, src_busy, accept, ready_q;
    alu_op_e                    dec_op;
    load_sz_e                   dec_sz;
    logic                       dec_uns;
    logic [`RVSEED_REG_NUM-1:0] pending_q, set_vec, clr_vec;
    issue_t                     issue_d;

    assign opcode   = inst_i.r_fmt.opcode;
    assign funct3   = inst_i.r_fmt.funct3;
    assign funct7   = inst_i.r_fmt.funct7;
    assign funct6   = inst_i.i_fmt.imm12[11:6];  // rv64 shift selector
    assign rd       = inst_i.r_fmt.rd;
    assign imm_sext = {{(`RVSEED_XLEN-12){inst_i.i_fmt.imm12[11]}}, inst_i.i_fmt.imm12};

    assign rs1_addr_o = inst_i.i_fmt.rs1;
    assign rs2_addr_o = inst_i.r_fmt.rs2;

    always_comb begin
        dec_illegal = 1'b0;
        dec_load    = 1'b0;
        dec_op      = ALU_ADD;
        dec_sz      = LD_D;
        dec_uns     = 1'b0;
        use_rs2     = 1'b0;
        case (opcode)
            `RVSEED_OPC_OP: begin
                use_rs2 = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: dec_op = ALU_ADD;
                    {7'h20, 3'b000}: dec_op = ALU_SUB;
                    {7'h00, 3'b001}: dec_op = ALU_SLL;
                    {7'h00, 3'b010}: dec_op = ALU_SLT;
                    {7'h00, 3'b011}: dec_op = ALU_SLTU;
                    {7'h00, 3'b100}: dec_op = ALU_XOR;
                    {7'h00, 3'b101}: dec_op = ALU_SRL;
                    {7'h20, 3'b101}: dec_op = ALU_SRA;
                    {7'h00, 3'b110}: dec_op = ALU_OR;
                    {7'h00, 3'b111}: dec_op = ALU_AND;
                    default:         dec_illegal = 1'b1;
                endcase
            end
            `RVSEED_OPC_OPIMM: begin
                case (funct3)
                    3'b000: dec_op = ALU_ADD;
                    3'b010: dec_op = ALU_SLT;
                    3'b011: dec_op = ALU_SLTU;
                    3'b100: dec_op = ALU_XOR;
                    3'b110: dec_op = ALU_OR;
                    3'b111: dec_op = ALU_AND;
                    3'b001: begin
                        dec_op      = ALU_SLL;
                        dec_illegal = (funct6 != 6'h00);
                    end
                    default: begin  // srli / srai
                        dec_op      = (funct6 == 6'h10) ? ALU_SRA : ALU_SRL;
                        dec_illegal = (funct6 != 6'h00) && (funct6 != 6'h10);
                    end
                endcase
            end
            `RVSEED_OPC_LOAD: begin
                dec_load    = 1'b1;
                dec_sz      = load_sz_e'(funct3[1:0]);
                dec_uns     = funct3[2];
                dec_illegal = (funct3 == 3'b111);  // no ldu
            end
            default: dec_illegal = 1'b1;
        endcase
    end

    // illegal words read nothing, so they never wait on the scoreboard
    assign src_busy = ~dec_illegal &
                      (pending_q[inst_i.i_fmt.rs1] | (use_rs2 & pending_q[inst_i.r_fmt.rs2]));
    assign inst_ready_o = ready_q & ~mem_busy_i & ~src_busy;
    assign accept       = inst_valid_i & inst_ready_o;

    always_comb begin
        set_vec = '0;
        clr_vec = '0;
        if (accept && !dec_load && !dec_illegal && rd != '0)
            set_vec[rd] = 1'b1;
        // keep the bit if a younger alu op with the same rd sits in the issue reg
        if (wb_port_i.wen && !(issue_o.valid && !issue_o.is_load && !issue_o.illegal &&
                               issue_o.rd == wb_port_i.waddr))
            clr_vec[wb_port_i.waddr] = 1'b1;
    end

    always_comb begin
        issue_d.valid   = accept;
        issue_d.is_load = dec_load & ~dec_illegal;
        issue_d.illegal = dec_illegal;
        issue_d.rd      = rd;
        issue_d.alu_op  = dec_op;
        issue_d.ld_sz   = dec_sz;
        issue_d.ld_uns  = dec_uns;
        issue_d.op_a    = rs1_data_i;
        issue_d.op_b    = use_rs2 ? rs2_data_i : imm_sext;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ready_q   <= 1'b0;
            pending_q <= '0;
            issue_o   <= '0;
        end else begin
            ready_q   <= 1'b1;
            pending_q <= (pending_q & ~clr_vec) | set_vec;  // set wins
            issue_o   <= issue_d;
        end
    end

endmodule

`default_nettype wire

// File: design/ex_stage.sv
// integer alu
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_defs.svh"

module ex_stage import rvseed_pkg::*; (
    input  wire          clk_i,
    input  wire          arst_n_i,
    input  wire issue_t  issue_i,
    output wb_t          alu_wb_o
);

    logic [`RVSEED_XLEN-1:0] a, b, res;
    logic [5:0]              shamt;

    assign a     = issue_i.op_a;
    assign b     = issue_i.op_b;
    assign shamt = b[5:0];

    always_comb begin
        case (issue_i.alu_op)
            ALU_ADD:  res = a + b;
            ALU_SUB:  res = a - b;
            ALU_SLL:  res = a << shamt;
            ALU_SLT:  res = {{(`RVSEED_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: res = {{(`RVSEED_XLEN-1){1'b0}}, a < b};
            ALU_XOR:  res = a ^ b;
            ALU_SRL:  res = a >> shamt;
            ALU_SRA:  res = $unsigned($signed(a) >>> shamt);
            ALU_OR:   res = a | b;
            ALU_AND:  res = a & b;
            default:  res = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alu_wb_o <= '0;
        end else begin
            alu_wb_o.valid   <= issue_i.valid & ~issue_i.is_load;
            alu_wb_o.rd      <= issue_i.illegal ? '0 : issue_i.rd;  // no write for illegal
            alu_wb_o.data    <= issue_i.illegal ? '0 : res;
            alu_wb_o.illegal <= issue_i.illegal;
            alu_wb_o.fault   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/mem_stage.sv
// load unit with axi4-lite read master
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_defs.svh"

module mem_stage import rvseed_pkg::*; (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire issue_t                 issue_i,
    input  wire                         arready_i,
    input  wire [`RVSEED_XLEN-1:0]      rdata_i,
    input  wire [1:0]                   rresp_i,
    input  wire                         rvalid_i,
    output logic [`RVSEED_AXI_AW-1:0]   araddr_o,
    output logic                        arvalid_o,
    output logic                        rready_o,
    output logic                        mem_busy_o,
    output wb_t                         mem_wb_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_DATA} state_e;

    state_e                     state_q;
    logic [`RVSEED_XLEN-1:0]    ea, lane, ext;
    logic [`RVSEED_AXI_AW-1:0]  addr_q;
    load_sz_e                   sz_q;
    logic                       uns_q, start, misaligned, resp_ok;
    logic [`RVSEED_REG_AW-1:0]  rd_q;

    assign start   = issue_i.valid & issue_i.is_load;
    assign ea      = issue_i.op_a + issue_i.op_b;
    assign resp_ok = (rresp_i == `RVSEED_RESP_OKAY);

    always_comb begin
        case (issue_i.ld_sz)
            LD_B:    misaligned = 1'b0;
            LD_H:    misaligned = ea[0];
            LD_W:    misaligned = |ea[1:0];
            default: misaligned = |ea[2:0];
        endcase
    end

    assign lane = rdata_i >> {addr_q[2:0], 3'b000};  // byte lane to bit 0

    always_comb begin
        case (sz_q)
            LD_B:    ext = {{(`RVSEED_XLEN-8){~uns_q & lane[7]}}, lane[7:0]};
            LD_H:    ext = {{(`RVSEED_XLEN-16){~uns_q & lane[15]}}, lane[15:0]};
            LD_W:    ext = {{(`RVSEED_XLEN-32){~uns_q & lane[31]}}, lane[31:0]};
            default: ext = lane;
        endcase
    end

    assign araddr_o  = {addr_q[`RVSEED_AXI_AW-1:3], 3'b000};
    assign arvalid_o = (state_q == ST_ADDR);
    assign rready_o  = (state_q == ST_DATA);
    // held until the register file has taken the result
    assign mem_busy_o = (state_q != ST_IDLE) | start | mem_wb_o.valid;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= ST_IDLE;
            mem_wb_o <= '0;
        end else begin
            mem_wb_o <= '0;
            case (state_q)
                ST_IDLE: begin
                    if (start && misaligned)
                        mem_wb_o <= '{valid: 1'b1, rd: '0, data: '0, illegal: 1'b0,
                                      fault: 1'b1};  // no bus access
                    else if (start)
                        state_q <= ST_ADDR;
                end
                ST_ADDR: begin
                    if (arready_i)
                        state_q <= ST_DATA;
                end
                default: begin
                    if (rvalid_i) begin
                        state_q  <= ST_IDLE;
                        mem_wb_o <= '{valid: 1'b1, rd: resp_ok ? rd_q : '0,
                                      data: resp_ok ? ext : '0, illegal: 1'b0,
                                      fault: ~resp_ok};
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && start) begin
            addr_q <= ea[`RVSEED_AXI_AW-1:0];
            sz_q   <= issue_i.ld_sz;
            uns_q  <= issue_i.ld_uns;
            rd_q   <= issue_i.rd;
        end
    end

endmodule

`default_nettype wire

// File: design/wb_stage.sv
// register file and retire
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_defs.svh"

module wb_stage import rvseed_pkg::*; (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire wb_t                    alu_wb_i,
    input  wire wb_t                    mem_wb_i,
    input  wire [`RVSEED_REG_AW-1:0]    rs1_addr_i,
    input  wire [`RVSEED_REG_AW-1:0]    rs2_addr_i,
    output logic [`RVSEED_XLEN-1:0]     rs1_data_o,
    output logic [`RVSEED_XLEN-1:0]     rs2_data_o,
    output rd_port_t                    wb_port_o,
    output retire_t                     retire_o
);

    logic [`RVSEED_XLEN-1:0] regs [`RVSEED_REG_NUM];
    wb_t                     sel;
    logic                    wen;

    // the two sources are never valid together
    assign sel = mem_wb_i.valid ? mem_wb_i : alu_wb_i;
    assign wen = sel.valid & (sel.rd != '0) & ~sel.illegal & ~sel.fault;

    assign wb_port_o.wen   = wen;
    assign wb_port_o.waddr = sel.rd;

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `RVSEED_REG_NUM; i++)
                regs[i] <= '0;
            retire_o <= '0;
        end else begin
            if (wen)
                regs[sel.rd] <= sel.data;
            retire_o <= retire_t'(sel);  // same layout as wb_t
        end
    end

endmodule

`default_nettype wire

// File: design/rvseed_top.sv
// rvseed integer back end
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_defs.svh"

module rvseed_top import rvseed_pkg::*; (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire                         inst_valid_i,
    input  wire [31:0]                  inst_i,
    output logic                        inst_ready_o,
    output retire_t                     retire_o,
    output logic [`RVSEED_AXI_AW-1:0]   araddr_o,
    output logic                        arvalid_o,
    input  wire                         arready_i,
    input  wire [`RVSEED_XLEN-1:0]      rdata_i,
    input  wire [1:0]                   rresp_i,
    input  wire                         rvalid_i,
    output logic                        rready_o
);

    issue_t                     issue;
    wb_t                        alu_wb, mem_wb;
    rd_port_t                   wb_port;
    logic [`RVSEED_REG_AW-1:0]  rs1_addr, rs2_addr;
    logic [`RVSEED_XLEN-1:0]    rs1_data, rs2_data;
    logic                       mem_busy;

    id_stage u_id_stage (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_u'(inst_i)),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .wb_port_i    (wb_port),   // scoreboard clear
        .mem_busy_i   (mem_busy),
        .inst_ready_o (inst_ready_o),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .issue_o      (issue)
    );

    ex_stage u_ex_stage (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .issue_i  (issue),
        .alu_wb_o (alu_wb)
    );

    mem_stage u_mem_stage (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .issue_i    (issue),
        .arready_i  (arready_i),
        .rdata_i    (rdata_i),
        .rresp_i    (rresp_i),
        .rvalid_i   (rvalid_i),
        .araddr_o   (araddr_o),
        .arvalid_o  (arvalid_o),
        .rready_o   (rready_o),
        .mem_busy_o (mem_busy),
        .mem_wb_o   (mem_wb)
    );

    wb_stage u_wb_stage (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .alu_wb_i   (alu_wb),
        .mem_wb_i   (mem_wb),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_port_o  (wb_port),
        .retire_o   (retire_o)
    );

endmodule

`default_nettype wire

// File: sim/tb_axi_mem.sv
// axi4-lite read responder
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_defs.svh"

module tb_axi_mem (
    input  wire                         clk_i,
    input  wire                         arst_n_i,
    input  wire [`RVSEED_AXI_AW-1:0]    araddr_i,
    input  wire                         arvalid_i,
    output logic                        arready_o,
    output logic [`RVSEED_XLEN-1:0]     rdata_o,
    output logic [1:0]                  rresp_o,
    output logic                        rvalid_o,
    input  wire                         rready_i
);

    logic [31:0] lcg_state, addr_q, araddr_s, r;
    logic [1:0]  ar_wait, r_wait;
    logic        pending, ar_hs, r_hs;

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // data of one doubleword, fixed per address
    function automatic logic [63:0] mem_hash(input logic [31:0] a);
        logic [31:0] d;
        d = a >> 3;
        return {(d * 32'h9e3779b9) ^ 32'h7f4a7c15, (d ^ 32'hd43a1f50) * 32'h85ebca6b};
    endfunction

    initial begin
        lcg_state = 32'hd43a1f50;
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        rdata_o   = '0;
        rresp_o   = `RVSEED_RESP_OKAY;
        pending   = 1'b0;
        addr_q    = '0;
        r         = next_rand();
        ar_wait   = r[17:16];
        r_wait    = 2'd0;
        forever begin
            @(posedge clk_i);
            ar_hs    = arvalid_i & arready_o;  // handshakes seen at the edge
            r_hs     = rvalid_o & rready_i;
            araddr_s = araddr_i;
            #2;
            if (!arst_n_i) begin
                arready_o = 1'b0;
                rvalid_o  = 1'b0;
                pending   = 1'b0;
            end else if (ar_hs) begin
                arready_o = 1'b0;
                addr_q    = araddr_s;
                pending   = 1'b1;
                r         = next_rand();
                r_wait    = r[17:16];
                r         = next_rand();
                ar_wait   = r[17:16];
            end else if (r_hs) begin
                rvalid_o = 1'b0;
                pending  = 1'b0;
            end else if (arvalid_i && !arready_o && !pending) begin
                if (ar_wait == 2'd0)
                    arready_o = 1'b1;
                else
                    ar_wait = ar_wait - 2'd1;
            end else if (pending && !rvalid_o) begin
                if (r_wait == 2'd0) begin
                    rvalid_o = 1'b1;
                    rdata_o  = mem_hash(addr_q);
                    rresp_o  = (addr_q >= 32'h0000_8000) ? 2'b10 : `RVSEED_RESP_OKAY;  // slverr
                end else begin
                    r_wait = r_wait - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_top.sv
// rvseed back end testbench
`timescale 1ns/1ps
`default_nettype none

`include "rvseed_defs.svh"

module tb_top import rvseed_pkg::*; ();

    localparam int N_RANDOM   = 400;
    localparam int WAIT_LIMIT = 500;

    logic                       clk, arst_n, inst_valid, inst_ready;
    logic [31:0]                inst;
    retire_t                    retire;
    logic [`RVSEED_AXI_AW-1:0]  araddr;
    logic                       arvalid, arready, rvalid, rready;
    logic [`RVSEED_XLEN-1:0]    rdata;
    logic [1:0]                 rresp;

    logic [31:0]                lcg_state;
    logic [`RVSEED_XLEN-1:0]    model_regs [`RVSEED_REG_NUM];
    retire_t                    exp_q [$];
    int                         dump_q [$];  // register index of a dump add, else -1
    logic [`RVSEED_AXI_AW-1:0]  ar_exp_q [$];  // doubleword address of each bus load
    int                         accept_cnt, retire_cnt, retire_errs, reg_errs, other_errs;
    int                         addr_errs;
    logic                       timeout_hit;
    logic                       ar_open;  // address taken, data beat still due

    rvseed_top dut0 (
        .clk_i (clk), .arst_n_i (arst_n),
        .inst_valid_i (inst_valid), .inst_i (inst), .inst_ready_o (inst_ready),
        .retire_o (retire),
        .araddr_o (araddr), .arvalid_o (arvalid), .arready_i (arready),
        .rdata_i (rdata), .rresp_i (rresp), .rvalid_i (rvalid), .rready_o (rready)
    );

    tb_axi_mem mem0 (
        .clk_i (clk), .arst_n_i (arst_n),
        .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
        .rdata_o (rdata), .rresp_o (rresp), .rvalid_o (rvalid), .rready_i (rready)
    );

    always #20 clk = ~clk;

    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'h0, lcg_state[31:16]};  // upper bits only
    endfunction

    function automatic logic [63:0] mem_hash(input logic [31:0] a);
        logic [31:0] d;
        d = a >> 3;
        return {(d * 32'h9e3779b9) ^ 32'h7f4a7c15, (d ^ 32'hd43a1f50) * 32'h85ebca6b};
    endfunction

    function automatic logic [63:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [63:0] a, input logic [63:0] b);
        logic [5:0] sh;
        sh = b[5:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return {63'd0, $signed(a) < $signed(b)};
            3'd3:    return {63'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [63:0] load_model(input logic [2:0] f3, input logic [63:0] word,
                                               input logic [2:0] off);
        logic [63:0] lane;
        lane = word >> {off, 3'b000};
        case (f3)
            3'd0:    return {{56{lane[7]}}, lane[7:0]};
            3'd1:    return {{48{lane[15]}}, lane[15:0]};
            3'd2:    return {{32{lane[31]}}, lane[31:0]};
            3'd4:    return {56'd0, lane[7:0]};
            3'd5:    return {48'd0, lane[15:0]};
            3'd6:    return {32'd0, lane[31:0]};
            default: return lane;
        endcase
    endfunction

    task automatic check_retire(input retire_t got, input retire_t exp);
        if (got.rd !== exp.rd) begin
            $display("** Error retire_o.rd: got %h expected %h", got.rd, exp.rd);
            retire_errs++;
        end
        if (got.data !== exp.data) begin
            $display("** Error retire_o.data: got %h expected %h", got.data, exp.data);
            retire_errs++;
        end
        if (got.illegal !== exp.illegal) begin
            $display("** Error retire_o.illegal: got %h expected %h", got.illegal, exp.illegal);
            retire_errs++;
        end
        if (got.fault !== exp.fault) begin
            $display("** Error retire_o.fault: got %h expected %h", got.fault, exp.fault);
            retire_errs++;
        end
    endtask

    task automatic check_reg(input int idx, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error register x%0d: got %h expected %h", idx, got, exp);
            reg_errs++;
        end
    endtask

    task automatic check_addr(input logic [`RVSEED_AXI_AW-1:0] got,
                              input logic [`RVSEED_AXI_AW-1:0] exp);
        if (got !== exp) begin
            $display("** Error araddr_o: got %h expected %h", got, exp);
            addr_errs++;
        end
    endtask

    // retire_o is registered, so it is stable at the falling edge
    always @(negedge clk) begin : retire_monitor
        retire_t e;
        int      tag;
        if (arst_n && retire.valid) begin
            retire_cnt++;
            if (exp_q.size() == 0) begin
                $display("retire seen with no accepted instruction left to retire");
                other_errs++;
            end else begin
                e   = exp_q.pop_front();
                tag = dump_q.pop_front();
                check_retire(retire, e);
                if (tag >= 0)
                    check_reg(tag, retire.data, model_regs[tag]);
            end
        end
    end

    // handshakes seen here complete at the next rising edge
    always @(negedge clk) begin : bus_monitor
        if (arst_n) begin
            if (rready && !ar_open) begin
                $display("rready_o is high with no read address accepted");
                other_errs++;
            end
            if (arvalid && arready) begin
                ar_open = 1'b1;
                if (ar_exp_q.size() == 0) begin
                    $display("read address sent with no bus load outstanding");
                    other_errs++;
                end else begin
                    check_addr(araddr, ar_exp_q.pop_front());
                end
            end
            if (rvalid && rready)
                ar_open = 1'b0;
        end
    end

    // called 2 ns after a rising edge; returns 2 ns after the accepting edge
    task automatic send(input logic [31:0] word, input retire_t exp, input int tag);
        int cnt;
        cnt        = 0;
        inst_valid = 1'b1;
        inst       = word;
        @(negedge clk);
        while (!inst_ready && cnt < WAIT_LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!inst_ready) begin
            $display("timed out waiting for the instruction port to become ready");
            other_errs++;
            timeout_hit = 1'b1;
            inst_valid  = 1'b0;
        end else begin
            exp_q.push_back(exp);
            dump_q.push_back(tag);
            accept_cnt++;
            @(posedge clk);
            #2;
            inst_valid = 1'b0;
        end
    endtask

    task automatic send_random();
        logic [31:0] r, word;
        logic [2:0]  f3;
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm, mask;
        logic [5:0]  sh;
        logic        alt, misal;
        logic [63:0] res, ea;
        retire_t     exp;
        exp       = '0;
        exp.valid = 1'b1;
        r   = next_rand();
        f3  = r[2:0];
        rd  = {2'b00, r[5:3]};  // few registers, many dependencies
        rs1 = {2'b00, r[8:6]};
        rs2 = {2'b00, r[11:9]};
        alt = r[12];
        r   = next_rand();
        if (r[3:0] < 4'd6) begin
            alt  = alt & (f3 == 3'd0 || f3 == 3'd5);
            word = {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, `RVSEED_OPC_OP};
            res  = alu_model(f3, alt, model_regs[rs1], model_regs[rs2]);
            exp.rd   = rd;
            exp.data = res;
        end else if (r[3:0] < 4'd11) begin
            imm = r[15:4];
            alt = 1'b0;
            if (f3 == 3'd1 || f3 == 3'd5) begin
                sh  = (r[5:4] == 2'd0) ? 6'd0 : (r[5:4] == 2'd1) ? 6'd63 : r[11:6];
                alt = (f3 == 3'd5) & r[12];
                imm = {1'b0, alt, 4'b0000, sh};
            end
            word = {imm, rs1, f3, rd, `RVSEED_OPC_OPIMM};
            res  = alu_model(f3, alt, model_regs[rs1], {{52{imm[11]}}, imm});
            exp.rd   = rd;
            exp.data = res;
        end else if (r[3:0] < 4'd14) begin
            f3   = (f3 == 3'd7) ? 3'd3 : f3;
            rs1  = (r[5:4] == 2'd0) ? rs1 : 5'd0;
            imm  = {(r[8:6] == 3'd0), r[15:5]};
            mask = 12'hfff << f3[1:0];
            if (r[10:9] != 2'd0)
                imm = imm & mask;
            word = {imm, rs1, f3, rd, `RVSEED_OPC_LOAD};
            ea   = model_regs[rs1] + {{52{imm[11]}}, imm};
            case (f3[1:0])
                2'd1:    misal = ea[0];
                2'd2:    misal = |ea[1:0];
                2'd3:    misal = |ea[2:0];
                default: misal = 1'b0;
            endcase
            if (!misal)
                ar_exp_q.push_back({ea[31:3], 3'b000});
            if (misal || ea[31:0] >= 32'h0000_8000) begin
                exp.fault = 1'b1;
            end else begin
                exp.rd   = rd;
                exp.data = load_model(f3, mem_hash(ea[31:0]), ea[2:0]);
            end
        end else begin
            if (r[4])
                word = {r[15:5], r[15:2], 7'b1111111};  // unknown opcode
            else
                word = {7'h01, rs2, rs1, f3, rd, `RVSEED_OPC_OP};  // mul group
            exp.illegal = 1'b1;
        end
        if (exp.rd != 5'd0)
            model_regs[exp.rd] = exp.data;
        send(word, exp, -1);
    endtask

    initial begin : main
        retire_t exp;
        int      cnt;
        clk         = 1'b0;
        arst_n      = 1'b0;
        inst_valid  = 1'b0;
        inst        = '0;
        lcg_state   = 32'hd43a1f50;
        accept_cnt  = 0;
        retire_cnt  = 0;
        retire_errs = 0;
        reg_errs    = 0;
        addr_errs   = 0;
        other_errs  = 0;
        timeout_hit = 1'b0;
        ar_open     = 1'b0;
        for (int i = 0; i < `RVSEED_REG_NUM; i++)
            model_regs[i] = '0;
        repeat (3) @(posedge clk);
        #2;
        arst_n = 1'b1;
        for (int i = 0; i < N_RANDOM && !timeout_hit; i++)
            send_random();
        // read back every register with add x0, xN, x0
        for (int i = 1; i < `RVSEED_REG_NUM && !timeout_hit; i++) begin
            exp = '{valid: 1'b1, rd: 5'd0, data: model_regs[i], illegal: 1'b0, fault: 1'b0};
            send({7'h00, 5'd0, i[4:0], 3'b000, 5'd0, `RVSEED_OPC_OP}, exp, i);
        end
        cnt = 0;
        while (retire_cnt != accept_cnt && cnt < WAIT_LIMIT) begin
            @(posedge clk);
            cnt++;
        end
        if (retire_cnt != accept_cnt) begin
            $display("retired %0d instructions but %0d were accepted", retire_cnt, accept_cnt);
            other_errs++;
        end
        $display("errors: retire %0d, register %0d, address %0d, other %0d", retire_errs,
                 reg_errs, addr_errs, other_errs);
        if (retire_errs + reg_errs + addr_errs + other_errs == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: rvseed_backend.f
+incdir+design
design/rvseed_pkg.sv
design/id_stage.sv
design/ex_stage.sv
design/mem_stage.sv
design/wb_stage.sv
design/rvseed_top.sv
sim/tb_axi_mem.sv
sim/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rvseed back end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f rvseed_backend.f \
    --top-module tb_top \
    --Mdir build_sim \
    -o tb_top_sim

./build_sim/tb_top_sim > sim.log 2>&1
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
    exit 0
else
    exit 1
fi
